//--- source/sb_pkg.sv
`default_nettype none

package sb_pkg;

    // One byte on the sideband wire
    typedef logic [7:0] sb_byte_t;

    // Frame layout is type byte, four payload bytes, then CRC
    localparam int FRAME_BODY_BYTES = 5;
    localparam int FRAME_IDX_BITS   = 3;
    localparam logic [FRAME_IDX_BITS-1:0] CRC_IDX = FRAME_IDX_BITS'(FRAME_BODY_BYTES);

    // Idle cycles inside a frame before it is dropped
    localparam int RX_GAP_LIMIT = 32;
    localparam int GAP_CNT_BITS = $clog2(RX_GAP_LIMIT);
    localparam logic [GAP_CNT_BITS-1:0] GAP_LAST = GAP_CNT_BITS'(RX_GAP_LIMIT - 1);

    localparam int NUM_LANES      = 64;
    localparam int ERR_COUNT_BITS = 16;

    // Message type codes
    localparam sb_byte_t MSG_PARAM_REQ = 8'h01;
    localparam sb_byte_t MSG_TRAIN_REQ = 8'h02;
    localparam sb_byte_t MSG_POWER_REQ = 8'h03;
    localparam sb_byte_t MSG_LANE_REQ  = 8'h04;

    localparam logic [1:0] POWER_L3 = 2'd3;   // Power ack after reset

    localparam sb_byte_t CRC8_POLY = 8'h07;

    // payload[7:0] is payload byte 1, first on the wire
    typedef struct packed {
        sb_byte_t    msg_type;
        logic [31:0] payload;
    } sb_msg_t;

    // CRC-8, MSB first, no reflection, zero seed
    function automatic sb_byte_t crc8_update(input sb_byte_t crc, input sb_byte_t data);
        sb_byte_t c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) begin
                c = (c << 1) ^ CRC8_POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

//--- source/sb_rx_deframer.sv
`timescale 1ns/1ps
`default_nettype none

module sb_rx_deframer (
    input  logic                              clk_sb,
    input  logic                              rst_n,
    input  sb_pkg::sb_byte_t                  sb_data_in,
    input  logic                              sb_valid_in,
    output logic                              sb_ready_out,
    output sb_pkg::sb_msg_t                   rx_msg,
    output logic                              rx_msg_valid,
    output logic [sb_pkg::ERR_COUNT_BITS-1:0] sb_error_count
);

    logic [sb_pkg::FRAME_IDX_BITS-1:0] byte_idx;   // Position of next byte in frame
    logic [sb_pkg::GAP_CNT_BITS-1:0]   gap_cnt;
    sb_pkg::sb_byte_t                  crc_q;
    sb_pkg::sb_msg_t                   msg_q;
    logic                              ready_q;
    logic                              xfer;
    logic                              crc_byte;
    logic                              gap_expired;
    logic                              err_inc;

    assign xfer     = sb_valid_in && ready_q;
    assign crc_byte = (byte_idx == sb_pkg::CRC_IDX);

    // Partial frame stalled for too long
    assign gap_expired = (byte_idx != '0) && !xfer && (gap_cnt == sb_pkg::GAP_LAST);

    assign err_inc = (xfer && crc_byte && (sb_data_in != crc_q)) || gap_expired;

    always_ff @(posedge clk_sb or negedge rst_n) begin
        if (!rst_n) begin
            byte_idx     <= '0;
            gap_cnt      <= '0;
            crc_q        <= '0;
            ready_q      <= 1'b0;
            rx_msg_valid <= 1'b0;
        end else begin
            ready_q      <= !(xfer && crc_byte);   // One dead cycle after each frame
            rx_msg_valid <= xfer && crc_byte && (sb_data_in == crc_q);
            if (xfer) begin
                gap_cnt <= '0;
                if (crc_byte) begin
                    byte_idx <= '0;
                    crc_q    <= '0;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                    crc_q    <= sb_pkg::crc8_update(crc_q, sb_data_in);
                end
            end else if (gap_expired) begin
                // Drop partial frame, next byte starts fresh
                byte_idx <= '0;
                crc_q    <= '0;
                gap_cnt  <= '0;
            end else if (byte_idx != '0) begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end
    end

    // Frame assembly
    always_ff @(posedge clk_sb) begin
        if (xfer) begin
            case (byte_idx)
                3'd0:    msg_q.msg_type       <= sb_data_in;
                3'd1:    msg_q.payload[7:0]   <= sb_data_in;
                3'd2:    msg_q.payload[15:8]  <= sb_data_in;
                3'd3:    msg_q.payload[23:16] <= sb_data_in;
                3'd4:    msg_q.payload[31:24] <= sb_data_in;
                default: ;                    // CRC byte is not stored
            endcase
        end
    end

    // Saturating error counter
    always_ff @(posedge clk_sb or negedge rst_n) begin
        if (!rst_n) begin
            sb_error_count <= '0;
        end else if (err_inc && (sb_error_count != '1)) begin
            sb_error_count <= sb_error_count + 1'b1;
        end
    end

    assign sb_ready_out = ready_q;
    assign rx_msg       = msg_q;

endmodule

`default_nettype wire

//--- source/sb_msg_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module sb_msg_decoder (
    input  logic                         clk_sb,
    input  logic                         rst_n,
    input  sb_pkg::sb_msg_t              rx_msg,
    input  logic                         rx_msg_valid,
    output logic [31:0]                  param_tx_data,
    output logic                         param_tx_valid,
    output logic [15:0]                  received_pattern,
    output logic                         training_complete,
    output logic [1:0]                   power_state_ack,
    output logic [sb_pkg::NUM_LANES-1:0] lane_enable_ack,
    output logic [7:0]                   width_ack
);

    logic [sb_pkg::NUM_LANES-1:0] lane_mask;
    logic                         is_param;
    logic                         is_train;

    assign is_param = rx_msg_valid && (rx_msg.msg_type == sb_pkg::MSG_PARAM_REQ);
    assign is_train = rx_msg_valid && (rx_msg.msg_type == sb_pkg::MSG_TRAIN_REQ);

    // Thermometer mask from lane count, saturates above NUM_LANES
    always_comb begin
        for (int i = 0; i < sb_pkg::NUM_LANES; i++) begin
            lane_mask[i] = (i < rx_msg.payload[7:0]);
        end
    end

    always_ff @(posedge clk_sb or negedge rst_n) begin
        if (!rst_n) begin
            param_tx_valid    <= 1'b0;
            training_complete <= 1'b0;
            power_state_ack   <= sb_pkg::POWER_L3;
            lane_enable_ack   <= '0;
            width_ack         <= '0;
        end else begin
            param_tx_valid    <= is_param;   // Single-cycle strobes
            training_complete <= is_train && (rx_msg.payload[23:16] == 8'h01);
            if (rx_msg_valid) begin
                case (rx_msg.msg_type)
                    sb_pkg::MSG_POWER_REQ: power_state_ack <= rx_msg.payload[1:0];
                    sb_pkg::MSG_LANE_REQ: begin
                        width_ack       <= rx_msg.payload[7:0];
                        lane_enable_ack <= lane_mask;
                    end
                    default: ;   // Unknown types leave state alone
                endcase
            end
        end
    end

    // Data captured alongside the strobes
    always_ff @(posedge clk_sb) begin
        if (is_param) begin
            param_tx_data <= rx_msg.payload;
        end
        if (is_train) begin
            received_pattern <= rx_msg.payload[15:0];   // Payload bytes 2 and 1
        end
    end

endmodule

`default_nettype wire

//--- source/sb_tx_framer.sv
`timescale 1ns/1ps
`default_nettype none

module sb_tx_framer (
    input  logic             clk_sb,
    input  logic             rst_n,
    input  sb_pkg::sb_msg_t  tx_msg,
    input  logic             tx_start,
    output logic             tx_busy,
    output sb_pkg::sb_byte_t sb_data,
    output logic             sb_valid,
    input  logic             sb_ready
);

    logic [sb_pkg::FRAME_IDX_BITS-1:0] byte_idx;
    sb_pkg::sb_byte_t                  crc_q;
    sb_pkg::sb_msg_t                   msg_q;
    logic                              busy_q;
    logic                              xfer;
    logic                              start_ok;

    assign xfer     = busy_q && sb_ready;
    assign start_ok = tx_start && !busy_q;   // Start while busy is dropped

    always_ff @(posedge clk_sb or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            byte_idx <= '0;
            crc_q    <= '0;
        end else if (start_ok) begin
            busy_q   <= 1'b1;
            byte_idx <= '0;
            crc_q    <= '0;
        end else if (xfer) begin
            if (byte_idx == sb_pkg::CRC_IDX) begin
                busy_q   <= 1'b0;   // CRC byte gone, frame done
                byte_idx <= '0;
            end else begin
                byte_idx <= byte_idx + 1'b1;
                crc_q    <= sb_pkg::crc8_update(crc_q, sb_data);
            end
        end
    end

    // Message held for the whole frame
    always_ff @(posedge clk_sb) begin
        if (start_ok) begin
            msg_q <= tx_msg;
        end
    end

    // Byte select, stable while the sink stalls
    always_comb begin
        case (byte_idx)
            3'd0:    sb_data = msg_q.msg_type;
            3'd1:    sb_data = msg_q.payload[7:0];
            3'd2:    sb_data = msg_q.payload[15:8];
            3'd3:    sb_data = msg_q.payload[23:16];
            3'd4:    sb_data = msg_q.payload[31:24];
            default: sb_data = crc_q;
        endcase
    end

    assign sb_valid = busy_q;
    assign tx_busy  = busy_q;

endmodule

`default_nettype wire

//--- source/sideband_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sideband_engine (
    input  logic                              clk_sb,
    input  logic                              rst_n,
    input  sb_pkg::sb_byte_t                  sb_data_in,
    input  logic                              sb_valid_in,
    output logic                              sb_ready_out,
    input  sb_pkg::sb_msg_t                   tx_msg,
    input  logic                              tx_start,
    output logic                              tx_busy,
    output sb_pkg::sb_byte_t                  sb_data,
    output logic                              sb_valid,
    input  logic                              sb_ready,
    output logic [31:0]                       param_tx_data,
    output logic                              param_tx_valid,
    output logic [15:0]                       received_pattern,
    output logic                              training_complete,
    output logic [1:0]                        power_state_ack,
    output logic [sb_pkg::NUM_LANES-1:0]      lane_enable_ack,
    output logic [7:0]                        width_ack,
    output logic [sb_pkg::ERR_COUNT_BITS-1:0] sb_error_count
);

    sb_pkg::sb_msg_t rx_msg;         // Frame from deframer
    logic            rx_msg_valid;   // Good CRC strobe

    sb_rx_deframer i_sb_rx_deframer (
        .clk_sb         (clk_sb),
        .rst_n          (rst_n),
        .sb_data_in     (sb_data_in),
        .sb_valid_in    (sb_valid_in),
        .sb_ready_out   (sb_ready_out),
        .rx_msg         (rx_msg),
        .rx_msg_valid   (rx_msg_valid),
        .sb_error_count (sb_error_count)
    );

    sb_msg_decoder i_sb_msg_decoder (
        .clk_sb            (clk_sb),
        .rst_n             (rst_n),
        .rx_msg            (rx_msg),
        .rx_msg_valid      (rx_msg_valid),
        .param_tx_data     (param_tx_data),
        .param_tx_valid    (param_tx_valid),
        .received_pattern  (received_pattern),
        .training_complete (training_complete),
        .power_state_ack   (power_state_ack),
        .lane_enable_ack   (lane_enable_ack),
        .width_ack         (width_ack)
    );

    sb_tx_framer i_sb_tx_framer (
        .clk_sb   (clk_sb),
        .rst_n    (rst_n),
        .tx_msg   (tx_msg),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .sb_data  (sb_data),
        .sb_valid (sb_valid),
        .sb_ready (sb_ready)
    );

endmodule

`default_nettype wire

//--- tb/sb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sb_checker (
    input  logic                              clk_sb,
    input  logic                              test_start,
    input  logic                              test_done,
    input  logic [7:0]                        test_op,
    input  sb_pkg::sb_msg_t                   test_msg,
    input  logic                              test_corrupt,
    input  logic                              test_gap,
    input  logic                              sb_valid_in,
    input  logic                              sb_ready_out,
    input  sb_pkg::sb_byte_t                  sb_data,
    input  logic                              sb_valid,
    input  logic                              sb_ready,
    input  logic                              tx_busy,
    input  logic [31:0]                       param_tx_data,
    input  logic                              param_tx_valid,
    input  logic [15:0]                       received_pattern,
    input  logic                              training_complete,
    input  logic [1:0]                        power_state_ack,
    input  logic [sb_pkg::NUM_LANES-1:0]      lane_enable_ack,
    input  logic [7:0]                        width_ack,
    input  logic [sb_pkg::ERR_COUNT_BITS-1:0] sb_error_count,
    output int                                pass_count,
    output int                                fail_count
);

    // Reference state of the decoder outputs
    logic [31:0]                       exp_param;
    logic [15:0]                       exp_pattern;
    logic [1:0]                        exp_power     = sb_pkg::POWER_L3;
    logic [sb_pkg::NUM_LANES-1:0]      exp_lane      = '0;
    logic [7:0]                        exp_width     = '0;
    logic [sb_pkg::ERR_COUNT_BITS-1:0] exp_errors    = '0;   // Error count after reset
    logic                              param_known   = 1'b0;   // No reset on data regs
    logic                              pattern_known = 1'b0;
    int                                test_num      = 0;
    int                                errs;
    int                                rx_xfers;
    int                                param_pulses;
    int                                train_pulses;
    sb_pkg::sb_byte_t                  tx_bytes[$];

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    // One clock of observation, sampled away from the active edge
    task automatic step();
        @(negedge clk_sb);
        param_pulses += int'(param_tx_valid);
        train_pulses += int'(training_complete);
        if (sb_valid_in && sb_ready_out) rx_xfers++;
        if (sb_valid && sb_ready) tx_bytes.push_back(sb_data);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR test %0d %s expected %h got %h", test_num, name, exp_v, act_v);
            errs++;
        end
    endtask

    task automatic check_decoder(input logic exp_pv, input logic exp_tc);
        if (param_known) check_value("param_tx_data", exp_param, param_tx_data);
        if (pattern_known) check_value("received_pattern", exp_pattern, received_pattern);
        check_value("power_state_ack", exp_power, power_state_ack);
        check_value("lane_enable_ack", exp_lane, lane_enable_ack);
        check_value("width_ack", exp_width, width_ack);
        check_value("param_tx_valid", exp_pv, param_tx_valid);
        check_value("training_complete", exp_tc, training_complete);
    endtask

    // Apply a good frame to the reference state
    task automatic predict_frame();
        logic [7:0] w;
        w = test_msg.payload[7:0];
        case (test_msg.msg_type)
            sb_pkg::MSG_PARAM_REQ: begin
                exp_param   = test_msg.payload;
                param_known = 1'b1;
            end
            sb_pkg::MSG_TRAIN_REQ: begin
                exp_pattern   = test_msg.payload[15:0];
                pattern_known = 1'b1;
            end
            sb_pkg::MSG_POWER_REQ: exp_power = test_msg.payload[1:0];
            sb_pkg::MSG_LANE_REQ: begin
                exp_width = w;
                if (w >= sb_pkg::NUM_LANES) begin
                    exp_lane = '1;
                end else begin
                    exp_lane = (sb_pkg::NUM_LANES'(1) << w) - 1'b1;
                end
            end
            default: ;
        endcase
    endtask

    task automatic run_rx();
        logic good;
        logic exp_pv;
        logic exp_tc;
        good    = !test_corrupt && !test_gap;
        exp_pv  = good && (test_msg.msg_type == sb_pkg::MSG_PARAM_REQ);
        exp_tc  = good && (test_msg.msg_type == sb_pkg::MSG_TRAIN_REQ) &&
                  (test_msg.payload[23:16] == 8'h01);
        if (!good && (exp_errors != '1)) exp_errors = exp_errors + 1'b1;   // Saturating
        if (good) predict_frame();
        while ((rx_xfers < 6) && !test_done) step();
        if (rx_xfers == 6) begin
            step();
            check_value("sb_ready_out", 1'b0, sb_ready_out);   // Dead cycle after CRC byte
            step();
            check_value("sb_ready_out", 1'b1, sb_ready_out);
            check_decoder(exp_pv, exp_tc);   // Two cycles after the CRC byte
        end
        while (!test_done) step();
        check_decoder(1'b0, 1'b0);
        check_value("sb_error_count", exp_errors, sb_error_count);
        check_value("param_tx_valid pulse count", exp_pv, param_pulses);
        check_value("training_complete pulse count", exp_tc, train_pulses);
        if (rx_xfers != (test_gap ? 3 : 6)) begin
            $display("test %0d: deframer accepted %0d bytes, which is not the frame length",
                     test_num, rx_xfers);
            errs++;
        end
    endtask

    task automatic run_tx();
        sb_pkg::sb_byte_t exp_bytes[6];
        sb_pkg::sb_byte_t crc;
        exp_bytes[0] = test_msg.msg_type;
        crc          = sb_pkg::crc8_update(8'h00, exp_bytes[0]);
        for (int i = 1; i < 5; i++) begin
            exp_bytes[i] = test_msg.payload[8*(i-1) +: 8];   // Byte 1 goes first
            crc          = sb_pkg::crc8_update(crc, exp_bytes[i]);
        end
        exp_bytes[5] = crc;
        while ((tx_bytes.size() < 6) && !test_done) step();
        if (tx_bytes.size() == 6) begin
            step();
            check_value("tx_busy", 1'b0, tx_busy);
            check_value("sb_valid", 1'b0, sb_valid);
        end
        while (!test_done) step();
        if (tx_bytes.size() != 6) begin
            $display("test %0d: framer sent %0d bytes instead of six", test_num, tx_bytes.size());
            errs++;
        end else begin
            for (int i = 0; i < 6; i++) begin
                check_value($sformatf("sb_data byte %0d", i), exp_bytes[i], tx_bytes[i]);
            end
        end
    endtask

    always begin
        @(negedge clk_sb);
        if (test_start) begin
            test_num++;
            errs         = 0;
            rx_xfers     = 0;
            param_pulses = 0;
            train_pulses = 0;
            tx_bytes.delete();
            if (test_op == "T") begin
                run_tx();
            end else begin
                run_rx();
            end
            $display("test %0d %s type %h payload %h: %s", test_num, test_op,
                     test_msg.msg_type, test_msg.payload, (errs == 0) ? "pass" : "fail");
            if (errs == 0) pass_count++;
            else fail_count++;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_sideband_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sideband_engine;

    logic                              clk_sb = 1'b0;
    logic                              rst_n;
    sb_pkg::sb_byte_t                  sb_data_in;
    logic                              sb_valid_in;
    logic                              sb_ready_out;
    sb_pkg::sb_msg_t                   tx_msg;
    logic                              tx_start;
    logic                              tx_busy;
    sb_pkg::sb_byte_t                  sb_data;
    logic                              sb_valid;
    logic                              sb_ready;
    logic [31:0]                       param_tx_data;
    logic                              param_tx_valid;
    logic [15:0]                       received_pattern;
    logic                              training_complete;
    logic [1:0]                        power_state_ack;
    logic [sb_pkg::NUM_LANES-1:0]      lane_enable_ack;
    logic [7:0]                        width_ack;
    logic [sb_pkg::ERR_COUNT_BITS-1:0] sb_error_count;

    // Current test, handed to the checker
    logic                              test_start;
    logic                              test_done;
    logic [7:0]                        test_op;
    sb_pkg::sb_msg_t                   test_msg;
    logic                              test_corrupt;
    logic                              test_gap;
    int                                pass_count;
    int                                fail_count;

    logic [7:0]                        op_q[$];
    sb_pkg::sb_msg_t                   msg_q[$];
    logic [2:0]                        flag_q[$];   // corrupt, gap, back-pressure
    int                                fd;
    int                                cycles = 0;
    int                                limit  = 0;
    integer                            seed   = 32'hf32f5e2c;

    sideband_engine i_sideband_engine (.*);

    sb_checker i_sb_checker (.*);

    always #5 clk_sb = ~clk_sb;

    always @(posedge clk_sb) begin
        cycles <= cycles + 1;
        if ((limit > 0) && (cycles >= limit)) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic read_stim(input int fd_in);
        string       line;
        logic [7:0]  op_c;
        logic [7:0]  ty;
        logic [31:0] pl;
        int          fc;
        int          fg;
        int          fb;
        while ($fgets(line, fd_in) > 0) begin
            // Comment lines fail to scan all six fields
            if ($sscanf(line, "%c %h %h %d %d %d", op_c, ty, pl, fc, fg, fb) == 6) begin
                op_q.push_back(op_c);
                msg_q.push_back(sb_pkg::sb_msg_t'({ty, pl}));
                flag_q.push_back({fc[0], fg[0], fb[0]});
            end
        end
        $fclose(fd_in);
    endtask

    task automatic send_rx(input sb_pkg::sb_msg_t m, input logic corrupt, input logic gap);
        sb_pkg::sb_byte_t frame[6];
        sb_pkg::sb_byte_t crc;
        frame[0] = m.msg_type;
        crc      = sb_pkg::crc8_update(8'h00, frame[0]);
        for (int k = 1; k < 5; k++) begin
            frame[k] = m.payload[8*(k-1) +: 8];
            crc      = sb_pkg::crc8_update(crc, frame[k]);
        end
        frame[5] = corrupt ? ~crc : crc;
        for (int k = 0; k < (gap ? 3 : 6); k++) begin
            @(posedge clk_sb);
            sb_data_in  <= frame[k];
            sb_valid_in <= 1'b1;
            @(negedge clk_sb);
            while (!sb_ready_out) @(negedge clk_sb);   // Byte moves on the next edge
        end
        @(posedge clk_sb);
        sb_valid_in <= 1'b0;
        if (gap) repeat (sb_pkg::RX_GAP_LIMIT + 4) @(posedge clk_sb);   // Frame left unfinished
    endtask

    task automatic send_tx(input sb_pkg::sb_msg_t m, input logic bp);
        logic        seen_busy;
        logic [31:0] rnd;
        seen_busy = 1'b0;
        tx_msg   <= m;
        tx_start <= 1'b1;
        sb_ready <= 1'b1;
        forever begin
            @(negedge clk_sb);
            if (tx_busy) seen_busy = 1'b1;
            else if (seen_busy) break;   // Busy fell, frame complete
            @(posedge clk_sb);
            tx_start <= 1'b0;
            rnd = $random(seed);
            sb_ready <= bp ? rnd[0] : 1'b1;
        end
        @(posedge clk_sb);
        sb_ready <= 1'b0;
    endtask

    task automatic run_test(input int i);
        @(posedge clk_sb);
        test_op                <= op_q[i];
        test_msg               <= msg_q[i];
        {test_corrupt, test_gap} <= flag_q[i][2:1];
        test_start             <= 1'b1;
        @(posedge clk_sb);
        test_start <= 1'b0;
        if (op_q[i] == "T") begin
            send_tx(msg_q[i], flag_q[i][0]);
        end else begin
            send_rx(msg_q[i], flag_q[i][2], flag_q[i][1]);
        end
        repeat (4) @(posedge clk_sb);
        test_done <= 1'b1;
        @(posedge clk_sb);
        test_done <= 1'b0;
        repeat (8) @(posedge clk_sb);
    endtask

    initial begin
        rst_n        = 1'b0;
        sb_data_in   = '0;
        sb_valid_in  = 1'b0;
        tx_msg       = '0;
        tx_start     = 1'b0;
        sb_ready     = 1'b0;
        test_start   = 1'b0;
        test_done    = 1'b0;
        test_op      = '0;
        test_msg     = '0;
        test_corrupt = 1'b0;
        test_gap     = 1'b0;
        fd = $fopen("tb/sb_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/sb_stim.txt");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            read_stim(fd);
            limit = op_q.size() * 200 + 100;
            repeat (4) @(posedge clk_sb);
            rst_n <= 1'b1;
            repeat (2) @(posedge clk_sb);
            foreach (op_q[i]) run_test(i);
            $display("tests %0d, passed %0d, failed %0d", op_q.size(), pass_count, fail_count);
            if ((fail_count == 0) && (pass_count == op_q.size()) && (op_q.size() > 0)) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/sb_stim.txt
# op type payload corrupt gap backpressure
# R sends a frame to the deframer, T has the framer transmit the message
R 01 deadbeef 0 0 0
R 02 00011234 0 0 0
R 02 00005678 0 0 0
R 03 00000001 0 0 0
R 04 00000010 0 0 0
R 04 00000050 0 0 0
R 04 00000040 0 0 0
R 01 12345678 1 0 0
R 03 00000002 0 1 0
R 03 00000002 0 0 0
R 09 cafef00d 0 0 0
R 04 00000000 0 0 0
T 01 a5a55a5a 0 0 0
T 04 89abcdef 0 0 1
T 02 0badf00d 0 0 1

//--- files.f
source/sb_pkg.sv
source/sb_rx_deframer.sv
source/sb_msg_decoder.sv
source/sb_tx_framer.sv
source/sideband_engine.sv
tb/sb_checker.sv
tb/tb_sideband_engine.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sideband engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_sideband_engine -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    || { echo "Build or run error"; exit 1; }
grep -q "SIMULATION PASSED" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
